// File: design/icache_cfg_pkg.sv
// --------------------------------------
// Geometry of the L1 I-cache. SETS must be a power of two, at least MIN_SETS
// --------------------------------------

package icache_cfg_pkg;

  // Physical address and line geometry
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned LINE_W   = 128;
  // Byte offset inside one line
  localparam int unsigned OFFSET_W = $clog2(LINE_W / 8);

  // Default cache shape, overridden from the top level
  localparam int unsigned DEF_SETS       = 16;
  localparam int unsigned DEF_WAYS       = 2;
  localparam int unsigned DEF_L2_CREDITS = 2;

  // Smallest legal set count, sizes the widest tag
  localparam int unsigned MIN_SETS  = 2;
  localparam int unsigned TAG_MAX_W = ADDR_W - OFFSET_W - $clog2(MIN_SETS);

  // Tag width actually used for a given set count
  function automatic int unsigned tag_w(input int unsigned sets);
    return ADDR_W - OFFSET_W - $clog2(sets);
  endfunction

endpackage

// File: design/icache_if_pkg.sv
// --------------------------------------
// Channel structs of the L1 I-cache. Valid bits are single-cycle qualifiers
// --------------------------------------

package icache_if_pkg;

  // Front-end fetch request, physical address only
  typedef struct packed {
    logic                              valid;
    logic [icache_cfg_pkg::ADDR_W-1:0] paddr;
  } fe_req_t;

  // Front-end response
  // err set when the L2 refill failed, line is then meaningless
  typedef struct packed {
    logic                              valid;
    logic                              err;
    logic [icache_cfg_pkg::LINE_W-1:0] line;
  } fe_resp_t;

  // Line refill request towards L2
  typedef struct packed {
    logic                                                        valid;
    logic [icache_cfg_pkg::ADDR_W-icache_cfg_pkg::OFFSET_W-1:0] line_addr;
  } l2_req_t;

  // Refill data from L2, always accepted
  typedef struct packed {
    logic                              valid;
    logic                              err;
    logic [icache_cfg_pkg::LINE_W-1:0] line;
  } l2_resp_t;

  // One way's read-out
  // Tag zero-extended to the widest tag
  typedef struct packed {
    logic                                 valid;
    logic [icache_cfg_pkg::TAG_MAX_W-1:0] tag;
    logic [icache_cfg_pkg::LINE_W-1:0]    line;
  } way_entry_t;

endpackage

// File: design/icache_way.sv
// --------------------------------------
// One I-cache way in flops. Read data lags the index by one cycle
// --------------------------------------
`timescale 1ns/1ns

module icache_way #(
  parameter  int unsigned SETS  = icache_cfg_pkg::DEF_SETS,
  localparam int unsigned IDX_W = $clog2(SETS),
  localparam int unsigned TAG_W = icache_cfg_pkg::tag_w(SETS)
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [IDX_W-1:0]                  rd_idx_i,
  input  logic                              wr_en_i,
  input  logic                              clr_i,
  input  logic [IDX_W-1:0]                  wr_idx_i,
  input  logic [TAG_W-1:0]                  wr_tag_i,
  input  logic [icache_cfg_pkg::LINE_W-1:0] wr_line_i,
  output icache_if_pkg::way_entry_t         entry_o
);
  import icache_cfg_pkg::*;

  // Storage
  logic [SETS-1:0]   valid_q;
  logic [TAG_W-1:0]  tag_mem  [SETS];
  logic [LINE_W-1:0] line_mem [SETS];

  // Read registers
  logic              rd_valid_q;
  logic [TAG_W-1:0]  rd_tag_q;
  logic [LINE_W-1:0] rd_line_q;

  // Valid bits, cleared by reset and by flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      // Read sees the value before a same-cycle write
      rd_valid_q <= valid_q[rd_idx_i];
      if (wr_en_i) begin
        valid_q[wr_idx_i] <= 1'b1;
      end else if (clr_i) begin
        valid_q[wr_idx_i] <= 1'b0;
      end
    end
  end

  // Tag and line arrays
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      tag_mem[wr_idx_i]  <= wr_tag_i;
      line_mem[wr_idx_i] <= wr_line_i;
    end
    rd_tag_q  <= tag_mem[rd_idx_i];
    rd_line_q <= line_mem[rd_idx_i];
  end

  assign entry_o.valid = rd_valid_q;
  assign entry_o.tag   = TAG_MAX_W'(rd_tag_q);
  assign entry_o.line  = rd_line_q;

  // Refill and flush are mutually exclusive in the controller
  a_no_wr_clr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wr_en_i && clr_i));

endmodule

// File: design/icache_hit_sel.sv
// --------------------------------------
// Tag compare across all ways, purely combinational
// --------------------------------------
`timescale 1ns/1ns

module icache_hit_sel #(
  parameter int unsigned WAYS = icache_cfg_pkg::DEF_WAYS
) (
  input  icache_if_pkg::way_entry_t [WAYS-1:0] entries_i,
  input  logic [icache_cfg_pkg::TAG_MAX_W-1:0] tag_i,
  output logic                                 hit_o,
  output logic [icache_cfg_pkg::LINE_W-1:0]    line_o,
  output logic [WAYS-1:0]                      valid_vec_o
);

  // Per-way match
  logic [WAYS-1:0] match;

  always_comb begin
    line_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      valid_vec_o[w] = entries_i[w].valid;
      match[w]       = entries_i[w].valid && (entries_i[w].tag == tag_i);
      // OR-mux, at most one way contributes
      if (match[w]) begin
        line_o = line_o | entries_i[w].line;
      end
    end
  end

  assign hit_o = |match;

  // A line is only ever refilled into one way of a set
  always_comb begin
    a_onehot_match: assert final ($onehot0(match))
      else $error("icache_hit_sel: multiple ways hit, match=%b", match);
  end

endmodule

// File: design/icache_victim_sel.sv
// --------------------------------------
// Victim way: first invalid, else round-robin
// --------------------------------------
`timescale 1ns/1ns

module icache_victim_sel #(
  parameter  int unsigned WAYS  = icache_cfg_pkg::DEF_WAYS,
  localparam int unsigned PTR_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [WAYS-1:0] valid_vec_i,
  input  logic            refill_i,
  output logic [WAYS-1:0] victim_o
);

  logic [PTR_W-1:0] rr_q;
  logic             all_valid;

  assign all_valid = &valid_vec_i;

  always_comb begin
    // Round-robin way by default
    victim_o       = '0;
    victim_o[rr_q] = 1'b1;
    // Walk downwards so the lowest invalid way wins
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!valid_vec_i[w]) begin
        victim_o    = '0;
        victim_o[w] = 1'b1;
      end
    end
  end

  // Pointer only moves when a valid line gets evicted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (refill_i && all_valid) begin
      rr_q <= (rr_q == PTR_W'(WAYS - 1)) ? '0 : rr_q + 1'b1;
    end
  end

  a_victim_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot(victim_o));

endmodule

// File: design/icache_ctrl.sv
// --------------------------------------
// I-cache FSM and L2 credit counter. Blocking on misses, one miss in flight
// --------------------------------------
`timescale 1ns/1ns

module icache_ctrl #(
  parameter  int unsigned SETS       = icache_cfg_pkg::DEF_SETS,
  parameter  int unsigned L2_CREDITS = icache_cfg_pkg::DEF_L2_CREDITS,
  localparam int unsigned IDX_W      = $clog2(SETS),
  localparam int unsigned TAG_W      = icache_cfg_pkg::tag_w(SETS),
  localparam int unsigned CNT_W      = $clog2(L2_CREDITS + 1)
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 flush_i,
  input  logic                                 abort_i,
  input  icache_if_pkg::fe_req_t               fe_req_i,
  output logic                                 fe_ready_o,
  output icache_if_pkg::fe_resp_t              fe_resp_o,
  output icache_if_pkg::l2_req_t               l2_req_o,
  input  icache_if_pkg::l2_resp_t              l2_resp_i,
  input  logic                                 l2_credit_i,
  input  logic                                 hit_i,
  input  logic [icache_cfg_pkg::LINE_W-1:0]    hit_line_i,
  output logic [IDX_W-1:0]                     rd_idx_o,
  output logic [IDX_W-1:0]                     wr_idx_o,
  output logic [TAG_W-1:0]                     wr_tag_o,
  output logic [icache_cfg_pkg::LINE_W-1:0]    wr_line_o,
  output logic                                 wr_en_o,
  output logic                                 clr_o,
  output logic [icache_cfg_pkg::TAG_MAX_W-1:0] lookup_tag_o,
  output logic                                 refill_o
);
  import icache_cfg_pkg::*;

  typedef enum logic [2:0] {
    IDLE, LOOKUP, MISS_REQ, WAIT_L2, REFILL, REPLAY, FLUSH, DRAIN
  } state_e;

  state_e            state_q, state_d;
  logic [ADDR_W-1:0] addr_q;
  logic [LINE_W-1:0] line_q;
  logic [IDX_W-1:0]  flush_cnt_q;
  logic [CNT_W-1:0]  credit_q, credit_d;
  // Bus error seen, answered in the next cycle
  logic              err_q;
  logic              accept;
  logic              l2_fire;
  logic [IDX_W-1:0]  req_idx;
  logic [IDX_W-1:0]  held_idx;
  logic [TAG_W-1:0]  held_tag;

  assign req_idx  = fe_req_i.paddr[OFFSET_W +: IDX_W];
  assign held_idx = addr_q[OFFSET_W +: IDX_W];
  assign held_tag = addr_q[ADDR_W-1 -: TAG_W];

  // Ready when idle, or on a hit so hits pipeline back to back
  assign fe_ready_o = !abort_i &&
                      ((state_q == IDLE && !flush_i) || (state_q == LOOKUP && hit_i));
  assign accept     = fe_ready_o && fe_req_i.valid;
  // Request only with a credit in hand
  assign l2_fire    = (state_q == MISS_REQ) && (credit_q != '0) && !abort_i;

  assign fe_resp_o.valid = !abort_i && ((state_q == LOOKUP && hit_i) || err_q);
  assign fe_resp_o.err   = err_q;
  assign fe_resp_o.line  = hit_line_i;

  assign l2_req_o.valid     = l2_fire;
  assign l2_req_o.line_addr = addr_q[ADDR_W-1:OFFSET_W];

  // Read index: flush walk, new request, else the held address
  always_comb begin
    if (state_q == FLUSH) begin
      rd_idx_o = flush_cnt_q;
    end else if (accept) begin
      rd_idx_o = req_idx;
    end else begin
      rd_idx_o = held_idx;
    end
  end

  assign wr_idx_o     = (state_q == FLUSH) ? flush_cnt_q : held_idx;
  assign wr_tag_o     = held_tag;
  assign wr_line_o    = line_q;
  assign wr_en_o      = (state_q == REFILL);
  assign refill_o     = (state_q == REFILL);
  assign clr_o        = (state_q == FLUSH);
  assign lookup_tag_o = TAG_MAX_W'(held_tag);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:     if (flush_i) state_d = FLUSH;
                else if (accept) state_d = LOOKUP;
      LOOKUP:   if (!hit_i) state_d = MISS_REQ;
                else if (!accept) state_d = IDLE;
      MISS_REQ: if (l2_fire) state_d = WAIT_L2;
      WAIT_L2:  if (l2_resp_i.valid) state_d = l2_resp_i.err ? IDLE : REFILL;
      REFILL:   state_d = REPLAY;
      // Replay re-reads the set, the hit then answers from LOOKUP
      REPLAY:   state_d = LOOKUP;
      FLUSH:    if (flush_cnt_q == IDX_W'(SETS - 1)) state_d = IDLE;
      DRAIN:    if (l2_resp_i.valid) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
    // Abort wins, but an outstanding L2 answer must still be swallowed
    if (abort_i && state_q != DRAIN) begin
      state_d = (state_q == WAIT_L2 && !l2_resp_i.valid) ? DRAIN : IDLE;
    end
  end

  always_comb begin
    credit_d = credit_q;
    if (l2_fire && !l2_credit_i) begin
      credit_d = credit_q - CNT_W'(1);
    end else if (!l2_fire && l2_credit_i) begin
      credit_d = credit_q + CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      credit_q    <= CNT_W'(L2_CREDITS);
      flush_cnt_q <= '0;
      err_q       <= 1'b0;
    end else begin
      state_q     <= state_d;
      credit_q    <= credit_d;
      flush_cnt_q <= (state_q == FLUSH) ? flush_cnt_q + 1'b1 : '0;
      err_q       <= (state_q == WAIT_L2) && l2_resp_i.valid && l2_resp_i.err && !abort_i;
    end
  end

  // Address and refill line
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fe_req_i.paddr;
    end
    if (state_q == WAIT_L2 && l2_resp_i.valid) begin
      line_q <= l2_resp_i.line;
    end
  end

  // L2 must not return more credits than it granted
  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CNT_W'(L2_CREDITS));

endmodule

// File: design/icache_top.sv
// --------------------------------------
// L1 I-cache top, physically addressed, front-end responses never stall
// --------------------------------------
`timescale 1ns/1ns

module icache_top #(
  parameter int unsigned SETS       = icache_cfg_pkg::DEF_SETS,
  parameter int unsigned WAYS       = icache_cfg_pkg::DEF_WAYS,
  parameter int unsigned L2_CREDITS = icache_cfg_pkg::DEF_L2_CREDITS
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     abort_i,
  input  icache_if_pkg::fe_req_t   fe_req_i,
  output logic                     fe_ready_o,
  output icache_if_pkg::fe_resp_t  fe_resp_o,
  output icache_if_pkg::l2_req_t   l2_req_o,
  input  icache_if_pkg::l2_resp_t  l2_resp_i,
  input  logic                     l2_credit_i
);
  import icache_cfg_pkg::*;
  import icache_if_pkg::*;

  localparam int unsigned IDX_W = $clog2(SETS);
  localparam int unsigned TAG_W = tag_w(SETS);

  // Controller to ways
  logic [IDX_W-1:0]     rd_idx;
  logic [IDX_W-1:0]     wr_idx;
  logic [TAG_W-1:0]     wr_tag;
  logic [LINE_W-1:0]    wr_line;
  logic                 wr_en;
  logic                 clr;
  logic                 refill;
  // Lookup path
  logic [TAG_MAX_W-1:0] lookup_tag;
  way_entry_t [WAYS-1:0] entries;
  logic                 hit;
  logic [LINE_W-1:0]    hit_line;
  logic [WAYS-1:0]      valid_vec;
  logic [WAYS-1:0]      victim;

  icache_ctrl #(.SETS(SETS), .L2_CREDITS(L2_CREDITS)) i_ctrl (
    .clk_i, .rst_ni, .flush_i, .abort_i,
    .fe_req_i, .fe_ready_o, .fe_resp_o,
    .l2_req_o, .l2_resp_i, .l2_credit_i,
    .hit_i(hit), .hit_line_i(hit_line),
    .rd_idx_o(rd_idx), .wr_idx_o(wr_idx), .wr_tag_o(wr_tag), .wr_line_o(wr_line),
    .wr_en_o(wr_en), .clr_o(clr), .lookup_tag_o(lookup_tag), .refill_o(refill)
  );

  // Refill lands only in the victim way, flush clears all ways
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    icache_way #(.SETS(SETS)) i_way (
      .clk_i, .rst_ni,
      .rd_idx_i(rd_idx), .wr_en_i(wr_en & victim[w]), .clr_i(clr),
      .wr_idx_i(wr_idx), .wr_tag_i(wr_tag), .wr_line_i(wr_line),
      .entry_o(entries[w])
    );
  end

  icache_hit_sel #(.WAYS(WAYS)) i_hit_sel (
    .entries_i(entries), .tag_i(lookup_tag),
    .hit_o(hit), .line_o(hit_line), .valid_vec_o(valid_vec)
  );

  icache_victim_sel #(.WAYS(WAYS)) i_victim_sel (
    .clk_i, .rst_ni,
    .valid_vec_i(valid_vec), .refill_i(refill), .victim_o(victim)
  );

endmodule

// File: verif/icache_tb.sv
// --------------------------------------
// Directed I-cache tests. Reference model assumes 16 sets of 16-byte lines
// --------------------------------------
`timescale 1ns/1ns

module icache_tb;
  import icache_if_pkg::*;

  localparam int SETS       = 16;
  localparam int WAYS       = 2;
  localparam int L2_CREDITS = 2;
  localparam int L2_LAT     = 4;
  // Longest test is about 120 cycles, all six stay well below this
  localparam int MAX_CYC    = 4000;
  localparam logic [127:0] LINE_XOR = {4{32'h5a3c_96e1}};

  logic clk_i, rst_ni, flush_i, abort_i, fe_ready_o, l2_credit_i;
  fe_req_t  fe_req_i;
  fe_resp_t fe_resp_o;
  l2_req_t  l2_req_o;
  l2_resp_t l2_resp_i;

  int errors = 0, tests_run = 0, cyc = 0;
  int l2_reqs = 0, l2_resps = 0, fe_resps = 0, req_base = 0, owed = 0;
  logic l2_err = 1'b0, hold_credits = 1'b0;
  logic [31:0] lfsr_q, fill_addr [4], repl_addr [3];
  logic [27:0] pend_addr [$];
  int pend_due [$];
  // Reference tags and the single round-robin pointer
  logic ref_valid [SETS][WAYS];
  logic [23:0] ref_tag [SETS][WAYS];
  int ref_rr = 0;

  icache_top #(.SETS(SETS), .WAYS(WAYS), .L2_CREDITS(L2_CREDITS)) DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    while (cyc < MAX_CYC) begin
      @(posedge clk_i);
      cyc++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYC);
    $display("ERRORS FOUND");
    $finish;
  end

  // Monitors, sampled mid-cycle
  always @(negedge clk_i) begin
    if (l2_req_o.valid) begin
      pend_addr.push_back(l2_req_o.line_addr);
      pend_due.push_back(cyc + L2_LAT);
      l2_reqs++;
    end
    if (l2_resp_i.valid) l2_resps++;
    if (fe_resp_o.valid) fe_resps++;
  end

  // L2 model, credit rides on the response unless withheld
  always @(posedge clk_i) begin
    #10;
    l2_resp_i   = '0;
    l2_credit_i = 1'b0;
    if (pend_addr.size() != 0 && cyc >= pend_due[0]) begin
      l2_resp_i.valid = 1'b1;
      l2_resp_i.err   = l2_err;
      l2_resp_i.line  = model_line(pend_addr.pop_front());
      void'(pend_due.pop_front());
      if (hold_credits) owed++;
      else l2_credit_i = 1'b1;
    end else if (!hold_credits && owed != 0) begin
      l2_credit_i = 1'b1;
      owed--;
    end
  end

  function automatic logic [127:0] model_line(input logic [27:0] la);
    return {4{4'h0, la}} ^ LINE_XOR;
  endfunction

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] make_addr(input logic [23:0] tag, input logic [3:0] set);
    return {tag, set, 4'h0};
  endfunction

  function automatic void clear_ref();
    for (int s = 0; s < SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        ref_valid[s][w] = 1'b0;
      end
    end
  endfunction

  function automatic logic ref_hit(input logic [31:0] a);
    for (int w = 0; w < WAYS; w++) begin
      if (ref_valid[a[7:4]][w] && ref_tag[a[7:4]][w] == a[31:8]) return 1'b1;
    end
    return 1'b0;
  endfunction

  // First invalid way, else round-robin
  function automatic void ref_fill(input logic [31:0] a);
    int v;
    v = -1;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!ref_valid[a[7:4]][w]) v = w;
    end
    if (v < 0) begin
      v = ref_rr;
      ref_rr = (ref_rr + 1) % WAYS;
    end
    ref_valid[a[7:4]][v] = 1'b1;
    ref_tag[a[7:4]][v]   = a[31:8];
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic report_mismatch(input string name, input string what,
                                 input logic [127:0] exp, input logic [127:0] act);
    $display("MISMATCH %s %s: expected %0h, actual %0h", name, what, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string name, input string msg);
    $display("%s: %s", name, msg);
    errors++;
  endtask

  task automatic finish_test(input string name, input int e0);
    tests_run++;
    if (errors == e0) $display("%s: passed", name);
    else $display("%s: failed with %0d errors", name, errors - e0);
  endtask

  // Holds the request until accepted
  task automatic send_req(input logic [31:0] addr);
    fe_req_i.valid = 1'b1;
    fe_req_i.paddr = addr;
    req_base = l2_reqs;
    do @(negedge clk_i); while (!fe_ready_o);
    next_cycle();
    fe_req_i.valid = 1'b0;
  endtask

  task automatic check_resp(input logic [31:0] addr, input logic exp_err, input string name);
    int lat;
    logic exp_hit;
    fe_resp_t got;
    exp_hit = ref_hit(addr);
    lat = 0;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!fe_resp_o.valid);
    got = fe_resp_o;
    next_cycle();
    assert (got.err == exp_err) else report_mismatch(name, "err", exp_err, got.err);
    assert (l2_reqs - req_base == (exp_hit ? 0 : 1))
      else report_mismatch(name, "l2 requests", exp_hit ? 0 : 1, l2_reqs - req_base);
    if (exp_hit) begin
      assert (lat == 1) else report_mismatch(name, "hit latency", 1, lat);
    end
    if (!exp_err) begin
      assert (got.line == model_line(addr[31:4]))
        else report_mismatch(name, "line", model_line(addr[31:4]), got.line);
      if (!exp_hit) ref_fill(addr);
    end
  endtask

  task automatic access(input logic [31:0] addr, input logic exp_err, input string name);
    send_req(addr);
    check_resp(addr, exp_err, name);
  endtask

  task automatic test_fill_hit();
    string name = "fill_hit";
    int e0 = errors;
    int base;
    // Distinct sets so no fill evicts another
    for (int i = 0; i < 4; i++) begin
      fill_addr[i] = make_addr(24'(rand_bits(24)), 4'(i));
      access(fill_addr[i], 1'b0, name);
    end
    for (int i = 0; i < 4; i++) access(fill_addr[i], 1'b0, name);
    base = l2_reqs;
    for (int i = 0; i <= 4; i++) begin
      fe_req_i.valid = (i < 4);
      fe_req_i.paddr = fill_addr[i % 4];
      @(negedge clk_i);
      if (i < 4) assert (fe_ready_o) else report_failure(name, "not ready during hit burst");
      if (i > 0) begin
        assert (fe_resp_o.valid) else report_failure(name, "hit burst response missing");
        assert (fe_resp_o.line == model_line(fill_addr[i-1][31:4]))
          else report_mismatch(name, "burst line", model_line(fill_addr[i-1][31:4]),
                               fe_resp_o.line);
      end
      next_cycle();
    end
    assert (l2_reqs == base) else report_mismatch(name, "burst l2 requests", 0, l2_reqs - base);
    finish_test(name, e0);
  endtask

  task automatic test_replace();
    string name = "replace";
    int e0 = errors;
    logic [23:0] t;
    t = 24'(rand_bits(24));
    for (int i = 0; i < 3; i++) begin
      repl_addr[i] = make_addr(t ^ 24'(i), 4'hf);
      access(repl_addr[i], 1'b0, name);
    end
    // Third fill evicted the first line
    access(repl_addr[1], 1'b0, name);
    access(repl_addr[2], 1'b0, name);
    access(repl_addr[0], 1'b0, name);
    finish_test(name, e0);
  endtask

  task automatic test_flush();
    string name = "flush";
    int e0 = errors;
    int low = 0;
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    forever begin
      @(negedge clk_i);
      if (fe_ready_o) break;
      low++;
    end
    next_cycle();
    assert (low == SETS) else report_mismatch(name, "ready low cycles", SETS, low);
    clear_ref();
    // Every line resident before the flush must miss now
    for (int i = 0; i < 4; i++) access(fill_addr[i], 1'b0, name);
    access(repl_addr[0], 1'b0, name);
    access(repl_addr[2], 1'b0, name);
    finish_test(name, e0);
  endtask

  task automatic test_bus_error();
    string name = "bus_error";
    int e0 = errors;
    logic [31:0] a;
    a = make_addr(24'(rand_bits(24)), 4'h5);
    l2_err = 1'b1;
    access(a, 1'b1, name);
    l2_err = 1'b0;
    access(a, 1'b0, name);
    finish_test(name, e0);
  endtask

  task automatic test_credits();
    string name = "credits";
    int e0 = errors;
    int rb;
    logic [31:0] a [3];
    for (int i = 0; i < 3; i++) a[i] = make_addr(24'(rand_bits(24)), 4'(8 + i));
    hold_credits = 1'b1;
    access(a[0], 1'b0, name);
    access(a[1], 1'b0, name);
    rb = fe_resps;
    send_req(a[2]);
    repeat (6) next_cycle();
    assert (l2_reqs == req_base) else report_failure(name, "l2 request sent without credit");
    assert (fe_resps == rb) else report_failure(name, "response given while starved");
    hold_credits = 1'b0;
    check_resp(a[2], 1'b0, name);
    finish_test(name, e0);
  endtask

  task automatic test_abort();
    string name = "abort";
    int e0 = errors;
    int rb, lb;
    logic [31:0] a;
    a = make_addr(24'(rand_bits(24)), 4'hb);
    send_req(a);
    while (l2_reqs == req_base) next_cycle();
    // Now waiting on L2
    rb = fe_resps;
    abort_i = 1'b1;
    next_cycle();
    abort_i = 1'b0;
    lb = l2_resps;
    while (l2_resps == lb) next_cycle();
    @(negedge clk_i);
    assert (fe_ready_o) else report_failure(name, "fe_ready_o did not return after abort");
    next_cycle();
    assert (fe_resps == rb) else report_failure(name, "aborted request got a response");
    access(a, 1'b0, name);
    finish_test(name, e0);
  endtask

  initial begin
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    abort_i     = 1'b0;
    fe_req_i    = '0;
    l2_resp_i   = '0;
    l2_credit_i = 1'b0;
    lfsr_q      = 32'hf6fe_825e;
    clear_ref();
    repeat (5) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (fe_ready_o && !fe_resp_o.valid && !l2_req_o.valid)
      else report_failure("reset", "outputs wrong after reset");
    next_cycle();
    test_fill_hit();
    test_replace();
    test_flush();
    test_bus_error();
    test_credits();
    test_abort();
    $display("Summary: %0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: flist.f
design/icache_cfg_pkg.sv
design/icache_if_pkg.sv
design/icache_way.sv
design/icache_hit_sel.sv
design/icache_victim_sel.sv
design/icache_ctrl.sv
design/icache_top.sv
verif/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  # Packages first, the structs depend on the geometry
  - design/icache_cfg_pkg.sv
  - design/icache_if_pkg.sv
  - design/icache_way.sv
  - design/icache_hit_sel.sv
  - design/icache_victim_sel.sv
  - design/icache_ctrl.sv
  - design/icache_top.sv
  - target: simulation
    files:
      - verif/icache_tb.sv
